/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import alu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     valid_i,
    input  alu_req_t req_i,
    output xlen_t    result_o,
    output logic     branch_res_o,
    output logic     valid_o
);

    xlen_t             sum;
    logic              zero;
    xlen_t             operand_b_inv;
    xlen_t             shift64;
    logic [WORD_W-1:0] shift32;
    logic              less;
    logic              branch_res;
    xlen_t             tb_max;
    xlen_t             tb_scale;
    xlen_t             tb_adds;
    xlen_t             tb_subs;
    xlen_t             tb_div_add;
    xlen_t             tb_div_sub;
    xlen_t             tb_sat63;
    xlen_t             tb_sb_sat;
    xlen_t             tb_shuffle;

    // ------------------------------------------------------------------
    // scalar units
    // ------------------------------------------------------------------
    alu_adder adder_inst (
        .req_i           (req_i),
        .sum_o           (sum),
        .zero_o          (zero),
        .operand_b_inv_o (operand_b_inv)
    );

    alu_shifter shifter_inst (
        .req_i     (req_i),
        .shift64_o (shift64),
        .shift32_o (shift32)
    );

    alu_compare compare_inst (
        .req_i        (req_i),
        .zero_i       (zero),
        .less_o       (less),
        .branch_res_o (branch_res)
    );

    // ------------------------------------------------------------------
    // lane units
    // ------------------------------------------------------------------
    turbo_lanes lanes_inst (
        .operand_a_i (req_i.operand_a),
        .operand_b_i (req_i.operand_b),
        .max_o       (tb_max),
        .scale_o     (tb_scale),
        .adds_o      (tb_adds),
        .subs_o      (tb_subs),
        .div_add_o   (tb_div_add),
        .div_sub_o   (tb_div_sub),
        .sat63_o     (tb_sat63),
        .sb_sat_o    (tb_sb_sat)
    );

    turbo_shuffle shuffle_inst (
        .operand_a_i (req_i.operand_a),
        .operand_b_i (req_i.operand_b),
        .shuffle_o   (tb_shuffle)
    );

    // select and register
    alu_result_stage result_stage_inst (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .valid_i         (valid_i),
        .req_i           (req_i),
        .sum_i           (sum),
        .operand_b_inv_i (operand_b_inv),
        .shift64_i       (shift64),
        .shift32_i       (shift32),
        .less_i          (less),
        .branch_res_i    (branch_res),
        .tb_max_i        (tb_max),
        .tb_scale_i      (tb_scale),
        .tb_adds_i       (tb_adds),
        .tb_subs_i       (tb_subs),
        .tb_shuffle_i    (tb_shuffle),
        .tb_div_add_i    (tb_div_add),
        .tb_div_sub_i    (tb_div_sub),
        .tb_sb_sat_i     (tb_sb_sat),
        .tb_sat63_i      (tb_sat63),
        .result_o        (result_o),
        .branch_res_o    (branch_res_o),
        .valid_o         (valid_o)
    );

endmodule

`default_nettype wire

/* alu_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_adder import alu_pkg::*; (
    input  alu_req_t req_i,
    output xlen_t    sum_o,
    output logic     zero_o,
    output xlen_t    operand_b_inv_o
);

    logic          negate_b;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] adder_in_b;
    logic [XLEN:0] adder_out;

    // ------------------------------------------------------------------
    // operand b inversion
    // ------------------------------------------------------------------
    always_comb begin
        negate_b = 1'b0;
        case (req_i.operator)
            EQ, NE,
            SUB, SUBW,
            ANDN, ORN, XNOR: begin
                negate_b = 1'b1;
            end
            default: begin
                negate_b = 1'b0;
            end
        endcase
    end

    // extra lsb carries the +1 of two's complement:
    // a gets a fixed 1, b gets the negate bit
    assign adder_in_a = {req_i.operand_a.scalar, 1'b1};
    assign adder_in_b = {req_i.operand_b.scalar, 1'b0} ^ {(XLEN + 1){negate_b}};

    // ------------------------------------------------------------------
    // extended add
    // ------------------------------------------------------------------
    assign adder_out = adder_in_a + adder_in_b;
    assign sum_o     = adder_out[XLEN:1];

    // equality for EQ and NE
    assign zero_o = ~|adder_out[XLEN:1];

    // logic ops reuse the conditionally inverted b
    assign operand_b_inv_o = adder_in_b[XLEN:1];

endmodule

`default_nettype wire

/* alu_compare.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_compare import alu_pkg::*; (
    input  alu_req_t req_i,
    input  logic     zero_i,
    output logic     less_o,
    output logic     branch_res_o
);

    logic          signed_cmp;
    logic [XLEN:0] cmp_a;
    logic [XLEN:0] cmp_b;

    // signed forms only
    assign signed_cmp = (req_i.operator == SLTS) ||
                        (req_i.operator == LTS)  ||
                        (req_i.operator == GES);

    // one extra bit turns both kinds into a signed compare
    assign cmp_a = {signed_cmp & req_i.operand_a.scalar[XLEN-1], req_i.operand_a.scalar};
    assign cmp_b = {signed_cmp & req_i.operand_b.scalar[XLEN-1], req_i.operand_b.scalar};

    assign less_o = $signed(cmp_a) < $signed(cmp_b);

    // ------------------------------------------------------------------
    // branch resolution
    // ------------------------------------------------------------------
    always_comb begin
        case (req_i.operator)
            EQ: begin
                branch_res_o = zero_i;
            end
            NE: begin
                branch_res_o = ~zero_i;
            end
            LTS, LTU: begin
                branch_res_o = less_o;
            end
            GES, GEU: begin
                branch_res_o = ~less_o;
            end
            // not a branch
            default: begin
                branch_res_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int XLEN       = 64;
    localparam int WORD_W     = 32;
    localparam int LANE_W     = 8;
    localparam int NUM_LANES  = XLEN / LANE_W;

    // shuffle reaches the low four bytes only
    localparam int SHUF_LANES = 4;
    localparam int SHUF_IDX_W = 4;

    // turbo clamp bound
    localparam int SAT_LIMIT  = 63;

    // ------------------------------------------------------------------
    // operators
    // ------------------------------------------------------------------
    typedef enum logic [5:0] {
        // adder
        ADD, SUB, ADDW, SUBW,
        // logic, the N forms use inverted operand b
        ANDL, ORL, XORL, ANDN, ORN, XNOR,
        // shifts
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        // set less than
        SLTS, SLTU,
        // branches
        EQ, NE, LTS, LTU, GES, GEU,
        // packed 8-bit lane ops
        TB_MAX, TB_SCALE, TB_ADDS, TB_SUBS, TB_SHUFFLE,
        TB_DIV_ADD, TB_DIV_SUB, TB_SB_SAT, TB_SAT_63
    } alu_op_e;

    // ------------------------------------------------------------------
    // data types
    // ------------------------------------------------------------------
    typedef logic [XLEN-1:0] xlen_t;

    // named signed element so lane selects keep their sign
    typedef logic signed [LANE_W-1:0] lane_t;

    // one operand word, seen as a scalar or as signed byte lanes
    typedef union packed {
        xlen_t                     scalar;
        lane_t [NUM_LANES-1:0]     lanes;
    } simd_word_u;

    // issue request, 134 bits
    typedef struct packed {
        alu_op_e    operator;
        simd_word_u operand_a;
        simd_word_u operand_b;
    } alu_req_t;

endpackage

`default_nettype wire

/* alu_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage import alu_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              valid_i,
    input  alu_req_t          req_i,
    input  xlen_t             sum_i,
    input  xlen_t             operand_b_inv_i,
    input  xlen_t             shift64_i,
    input  logic [WORD_W-1:0] shift32_i,
    input  logic              less_i,
    input  logic              branch_res_i,
    input  xlen_t             tb_max_i,
    input  xlen_t             tb_scale_i,
    input  xlen_t             tb_adds_i,
    input  xlen_t             tb_subs_i,
    input  xlen_t             tb_shuffle_i,
    input  xlen_t             tb_div_add_i,
    input  xlen_t             tb_div_sub_i,
    input  xlen_t             tb_sb_sat_i,
    input  xlen_t             tb_sat63_i,
    output xlen_t             result_o,
    output logic              branch_res_o,
    output logic              valid_o
);

    xlen_t operand_a;
    xlen_t result_d;

    assign operand_a = req_i.operand_a.scalar;

    // ------------------------------------------------------------------
    // result select
    // ------------------------------------------------------------------
    always_comb begin
        result_d = '0;
        case (req_i.operator)
            // lane ops
            TB_MAX:     result_d = tb_max_i;
            TB_SCALE:   result_d = tb_scale_i;
            TB_ADDS:    result_d = tb_adds_i;
            TB_SUBS:    result_d = tb_subs_i;
            TB_SHUFFLE: result_d = tb_shuffle_i;
            TB_DIV_ADD: result_d = tb_div_add_i;
            TB_DIV_SUB: result_d = tb_div_sub_i;
            TB_SB_SAT:  result_d = tb_sb_sat_i;
            TB_SAT_63:  result_d = tb_sat63_i;

            // b already inverted for the N forms
            ANDL, ANDN: result_d = operand_a & operand_b_inv_i;
            ORL, ORN:   result_d = operand_a | operand_b_inv_i;
            XORL, XNOR: result_d = operand_a ^ operand_b_inv_i;

            ADD, SUB:   result_d = sum_i;
            // word ops sign extend bit 31
            ADDW, SUBW: result_d = {{(XLEN - WORD_W){sum_i[WORD_W-1]}}, sum_i[WORD_W-1:0]};

            SLL, SRL, SRA:    result_d = shift64_i;
            SLLW, SRLW, SRAW: result_d = {{(XLEN - WORD_W){shift32_i[WORD_W-1]}}, shift32_i};

            SLTS, SLTU: result_d = {{(XLEN - 1){1'b0}}, less_i};

            // branches leave the result at zero
            default:    result_d = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // output register, one cycle latency
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o      <= 1'b0;
            result_o     <= '0;
            branch_res_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // hold the last result between requests
            if (valid_i) begin
                result_o     <= result_d;
                branch_res_o <= branch_res_i;
            end
        end
    end

endmodule

`default_nettype wire

/* alu_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_shifter import alu_pkg::*; (
    input  alu_req_t          req_i,
    output xlen_t             shift64_o,
    output logic [WORD_W-1:0] shift32_o
);

    logic                        shift_left;
    logic                        shift_arith;
    logic [$clog2(XLEN)-1:0]     amt64;
    logic [$clog2(WORD_W)-1:0]   amt32;
    xlen_t                       shift_in64;
    logic [WORD_W-1:0]           shift_in32;
    logic [XLEN:0]               right64_ext;
    logic [WORD_W:0]             right32_ext;

    function automatic xlen_t rev_xlen(input xlen_t value);
        xlen_t rev;
        for (int k = 0; k < XLEN; k++) begin
            rev[k] = value[XLEN-1-k];
        end
        return rev;
    endfunction

    function automatic logic [WORD_W-1:0] rev_word(input logic [WORD_W-1:0] value);
        logic [WORD_W-1:0] rev;
        for (int k = 0; k < WORD_W; k++) begin
            rev[k] = value[WORD_W-1-k];
        end
        return rev;
    endfunction

    assign shift_left  = (req_i.operator == SLL) || (req_i.operator == SLLW);
    assign shift_arith = (req_i.operator == SRA) || (req_i.operator == SRAW);

    assign amt64 = req_i.operand_b.scalar[$clog2(XLEN)-1:0];
    assign amt32 = req_i.operand_b.scalar[$clog2(WORD_W)-1:0];

    // ------------------------------------------------------------------
    // one right shifter, left shifts run on the reversed operand
    // ------------------------------------------------------------------
    assign shift_in64 = shift_left ? rev_xlen(req_i.operand_a.scalar)
                                   : req_i.operand_a.scalar;
    assign shift_in32 = shift_left ? rev_word(req_i.operand_a.scalar[WORD_W-1:0])
                                   : req_i.operand_a.scalar[WORD_W-1:0];

    // extra msb is the fill bit, sign only for arithmetic shifts
    assign right64_ext = $unsigned($signed({shift_arith & shift_in64[XLEN-1],
                                            shift_in64}) >>> amt64);
    assign right32_ext = $unsigned($signed({shift_arith & shift_in32[WORD_W-1],
                                            shift_in32}) >>> amt32);

    // undo the reversal for left shifts
    assign shift64_o = shift_left ? rev_xlen(right64_ext[XLEN-1:0])
                                  : right64_ext[XLEN-1:0];
    assign shift32_o = shift_left ? rev_word(right32_ext[WORD_W-1:0])
                                  : right32_ext[WORD_W-1:0];

endmodule

`default_nettype wire

/* compile.f */
alu_pkg.sv
alu_adder.sv
alu_shifter.sv
alu_compare.sv
turbo_lanes.sv
turbo_shuffle.sv
alu_result_stage.sv
alu.sv
tb_alu.sv

/* tb_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_alu import alu_pkg::*; ();

    localparam int RESET_CYCLES = 8;

    logic     clk = 1'b0;
    logic     rst;
    logic     valid_in;
    alu_req_t req;
    xlen_t    result;
    logic     branch_res;
    logic     valid_out;

    // stimulus table, one column per queue
    string    names[$];
    alu_op_e  ops[$];
    xlen_t    op_a[$];
    xlen_t    op_b[$];
    xlen_t    exp_result[$];
    logic     exp_branch[$];

    int       cycle_count   = 0;
    int       timeout_limit = 1000;

    always #2 clk = ~clk;

    alu alu_inst (
        .clk_i        (clk),
        .rst_i        (rst),
        .valid_i      (valid_in),
        .req_i        (req),
        .result_o     (result),
        .branch_res_o (branch_res),
        .valid_o      (valid_out)
    );

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic add_entry(input string name, input alu_op_e op, input xlen_t a,
                             input xlen_t b, input xlen_t res, input logic br);
        names.push_back(name);
        ops.push_back(op);
        op_a.push_back(a);
        op_b.push_back(b);
        exp_result.push_back(res);
        exp_branch.push_back(br);
    endtask

    task automatic check_value(input string test, input string signal,
                               input xlen_t expected, input xlen_t actual);
        assert (actual === expected) else
            fail_run($sformatf("** Error %s: %s expected %0h, actual %0h",
                               test, signal, expected, actual));
    endtask

    task automatic drive_entry(input int idx);
        req.operator        = ops[idx];
        req.operand_a.scalar = op_a[idx];
        req.operand_b.scalar = op_b[idx];
        valid_in            = 1'b1;
    endtask

    task automatic drive_idle();
        // unequal EQ so a lost hold would show 0 on both outputs
        req                  = '0;
        req.operator         = EQ;
        req.operand_a.scalar = 64'h1;
        valid_in             = 1'b0;
    endtask

    task automatic check_entry(input int idx);
        assert (valid_out === 1'b1) else
            fail_run($sformatf("valid_o stayed low one cycle after request %s", names[idx]));
        check_value(names[idx], "result_o", exp_result[idx], result);
        check_value(names[idx], "branch_res_o", xlen_t'(exp_branch[idx]), xlen_t'(branch_res));
    endtask

    // no request in flight, outputs must hold
    task automatic check_idle(input string label, input xlen_t res, input logic br);
        assert (valid_out === 1'b0) else
            fail_run($sformatf("valid_o high with no request pending (%s)", label));
        check_value(label, "result_o", res, result);
        check_value(label, "branch_res_o", xlen_t'(br), xlen_t'(branch_res));
    endtask

    // ------------------------------------------------------------------
    // expected values worked out by hand per operator
    // ------------------------------------------------------------------
    task automatic build_table();
        // adder and logic
        add_entry("add_wrap",  ADD,  64'hFFFFFFFF_FFFFFFFF, 64'h2, 64'h00000000_00000001, 1);
        add_entry("add_plain", ADD,  64'h00000001_23456789, 64'h11111111,
                  64'h00000001_3456789A, 1);
        add_entry("sub_wrap",  SUB,  64'h0, 64'h1, 64'hFFFFFFFF_FFFFFFFF, 1);
        add_entry("sub_plain", SUB,  64'h64, 64'h20, 64'h44, 1);
        add_entry("addw_sext", ADDW, 64'h7FFFFFFF, 64'h1, 64'hFFFFFFFF_80000000, 1);
        add_entry("addw_high", ADDW, 64'h12345678_00000001, 64'h1, 64'h2, 1);
        add_entry("subw_sext", SUBW, 64'h0, 64'h1, 64'hFFFFFFFF_FFFFFFFF, 1);
        add_entry("andl", ANDL, 64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                  64'hF000F000_F000F000, 1);
        add_entry("orl",  ORL,  64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                  64'hFFF0FFF0_FFF0FFF0, 1);
        add_entry("xorl", XORL, 64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                  64'h0FF00FF0_0FF00FF0, 1);
        add_entry("andn", ANDN, 64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                  64'h00F000F0_00F000F0, 1);
        add_entry("orn",  ORN,  64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                  64'hF0FFF0FF_F0FFF0FF, 1);
        add_entry("xnor", XNOR, 64'hF0F0F0F0_F0F0F0F0, 64'hFF00FF00_FF00FF00,
                  64'hF00FF00F_F00FF00F, 1);

        // shifts
        add_entry("sll_0",   SLL, 64'h80000000_00000081, 64'h0,  64'h80000000_00000081, 1);
        add_entry("sll_1",   SLL, 64'h80000000_00000081, 64'h1,  64'h00000000_00000102, 1);
        add_entry("sll_63",  SLL, 64'h80000000_00000081, 64'h3F, 64'h80000000_00000000, 1);
        add_entry("sll_amt", SLL, 64'h80000000_00000081, 64'h41, 64'h00000000_00000102, 1);
        add_entry("srl_0",   SRL, 64'h80000000_00000081, 64'h0,  64'h80000000_00000081, 1);
        add_entry("srl_1",   SRL, 64'h80000000_00000081, 64'h1,  64'h40000000_00000040, 1);
        add_entry("srl_63",  SRL, 64'h80000000_00000081, 64'h3F, 64'h00000000_00000001, 1);
        add_entry("sra_0",   SRA, 64'h80000000_00000081, 64'h0,  64'h80000000_00000081, 1);
        add_entry("sra_1",   SRA, 64'h80000000_00000081, 64'h1,  64'hC0000000_00000040, 1);
        add_entry("sra_63",  SRA, 64'h80000000_00000081, 64'h3F, 64'hFFFFFFFF_FFFFFFFF, 1);
        add_entry("sllw",    SLLW, 64'h40000001, 64'h1, 64'hFFFFFFFF_80000002, 1);
        add_entry("srlw",    SRLW, 64'hFFFFFFFF_80000000, 64'h4, 64'h00000000_08000000, 1);
        add_entry("sraw",    SRAW, 64'h80000000, 64'h4, 64'hFFFFFFFF_F8000000, 1);
        add_entry("srlw_sx", SRLW, 64'h80000000, 64'h0, 64'hFFFFFFFF_80000000, 1);

        // set less than
        add_entry("slts_neg",  SLTS, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h1, 1);
        add_entry("sltu_neg",  SLTU, 64'hFFFFFFFF_FFFFFFFF, 64'h1, 64'h0, 1);
        add_entry("slts_same", SLTS, 64'h5, 64'h5, 64'h0, 1);

        // branches, result stays zero
        add_entry("beq_taken", EQ,  64'h1234, 64'h1234, 64'h0, 1);
        add_entry("beq_not",   EQ,  64'h1234, 64'h1235, 64'h0, 0);
        add_entry("bne_taken", NE,  64'h1, 64'h2, 64'h0, 1);
        add_entry("bne_not",   NE,  64'h7, 64'h7, 64'h0, 0);
        add_entry("blt_neg",   LTS, 64'hFFFFFFFF_FFFFFFFF, 64'h0, 64'h0, 1);
        add_entry("bltu_big",  LTU, 64'hFFFFFFFF_FFFFFFFF, 64'h0, 64'h0, 0);
        add_entry("bge_neg",   GES, 64'hFFFFFFFF_FFFFFFFF, 64'h0, 64'h0, 0);
        add_entry("bgeu_big",  GEU, 64'hFFFFFFFF_FFFFFFFF, 64'h0, 64'h0, 1);
        add_entry("bge_equal", GES, 64'h3, 64'h3, 64'h0, 1);

        // turbo lanes, byte 7 first
        add_entry("tb_max",  TB_MAX,  64'h807F01FF_10F00005, 64'h7F8002FE_F01000FB,
                  64'h7F7F02FF_10100005, 1);
        add_entry("tb_adds", TB_ADDS, 64'h807F01FF_10F00005, 64'h7F8002FE_F01000FB,
                  64'hFFFF03FD_00000000, 1);
        add_entry("tb_subs", TB_SUBS, 64'h807F01FF_10F00005, 64'h7F8002FE_F01000FB,
                  64'h01FFFF01_20E0000A, 1);
        add_entry("tb_dadd", TB_DIV_ADD, 64'h807F01FF_10F00005, 64'h7F8002FE_F01000FB,
                  64'h7F7F017E_00000000, 1);
        add_entry("tb_dsub", TB_DIV_SUB, 64'h807F01FF_10F00005, 64'h7F8002FE_F01000FB,
                  64'h007F7F00_10700005, 1);
        add_entry("tb_sat",  TB_SAT_63, 64'h649C053F_C140C080, 64'h0,
                  64'h3FC1053F_C13FC1C1, 1);
        add_entry("tb_sbsat", TB_SB_SAT, 64'h649C053F_C140C080, 64'h01FF0500_80100102,
                  64'h3EC2003F_412FC0BF, 1);
        add_entry("tb_scale", TB_SCALE, 64'h28D88000_7FFF0304, 64'h0,
                  64'h1EE2A000_60FF0303, 1);

        // shuffle, lanes 4 to 7 never filled
        add_entry("shuf_perm",  TB_SHUFFLE, 64'h11223344_DDCCBBAA, 64'h00010203_00111203,
                  64'h00000000_AABBCCDD, 1);
        add_entry("shuf_mask",  TB_SHUFFLE, 64'h11223344_DDCCBBAA, 64'h0,
                  64'h00000000_AAAAAAAA, 1);
        add_entry("shuf_range", TB_SHUFFLE, 64'h11223344_DDCCBBAA, 64'h00000000_0F120104,
                  64'h00000000_00CC0000, 1);
        add_entry("shuf_ident", TB_SHUFFLE, 64'h11223344_DDCCBBAA, 64'h00000000_03021100,
                  64'h00000000_DDCCBBAA, 1);
    endtask

    // ------------------------------------------------------------------
    // timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            fail_run($sformatf("timeout after %0d cycles, the run did not finish", cycle_count));
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int num_entries;
        int last;

        rst      = 1'b1;
        valid_in = 1'b0;
        req      = '0;

        build_table();
        num_entries   = names.size();
        last          = num_entries - 1;
        timeout_limit = RESET_CYCLES + num_entries + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_idle("after_reset", 64'h0, 1'b0);

        // back to back, one request per cycle
        for (int i = 0; i <= num_entries; i++) begin
            if (i > 0) begin
                check_entry(i - 1);
            end
            if (i < num_entries) begin
                drive_entry(i);
            end else begin
                drive_idle();
            end
            @(negedge clk);
        end

        // valid drops, last result held
        check_idle("idle_hold", exp_result[last], exp_branch[last]);

        // a lone request after the gap
        drive_entry(0);
        @(negedge clk);
        check_entry(0);
        drive_idle();
        @(negedge clk);
        check_idle("idle_after_lone", exp_result[0], exp_branch[0]);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* turbo_lanes.sv */
`timescale 1ns/1ps
`default_nettype none

module turbo_lanes import alu_pkg::*; (
    input  simd_word_u operand_a_i,
    input  simd_word_u operand_b_i,
    output xlen_t      max_o,
    output xlen_t      scale_o,
    output xlen_t      adds_o,
    output xlen_t      subs_o,
    output xlen_t      div_add_o,
    output xlen_t      div_sub_o,
    output xlen_t      sat63_o,
    output xlen_t      sb_sat_o
);

    // ------------------------------------------------------------------
    // independent byte lanes, everything wraps at 8 bits
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        lane_t             lane_a;
        lane_t             lane_b;
        logic              a_neg;
        lane_t             mag;
        lane_t             mag_scaled;
        logic [LANE_W-1:0] sum;
        logic [LANE_W-1:0] diff;
        lane_t             sat;

        assign lane_a = operand_a_i.lanes[i];
        assign lane_b = operand_b_i.lanes[i];

        // signed max
        assign max_o[i*LANE_W +: LANE_W] = (lane_a <= lane_b) ? lane_b : lane_a;

        // scale by 3/4 on the magnitude
        // note -128 negates to itself and still gives 0xa0
        assign a_neg      = lane_a[LANE_W-1];
        assign mag        = a_neg ? -lane_a : lane_a;
        assign mag_scaled = mag - (mag >> 2);

        assign scale_o[i*LANE_W +: LANE_W] = a_neg ? -mag_scaled : mag_scaled;

        // plain wrapped add and sub
        assign sum  = lane_a + lane_b;
        assign diff = lane_a - lane_b;

        assign adds_o[i*LANE_W +: LANE_W] = sum;
        assign subs_o[i*LANE_W +: LANE_W] = diff;

        // halving is logical on the wrapped result
        assign div_add_o[i*LANE_W +: LANE_W] = sum >> 1;
        assign div_sub_o[i*LANE_W +: LANE_W] = diff >> 1;

        // clamp to +-SAT_LIMIT
        assign sat = (lane_a > SAT_LIMIT)  ? lane_t'(SAT_LIMIT)  :
                     (lane_a < -SAT_LIMIT) ? lane_t'(-SAT_LIMIT) :
                     lane_a;

        assign sat63_o[i*LANE_W +: LANE_W] = sat;

        // saturate first, then subtract b
        assign sb_sat_o[i*LANE_W +: LANE_W] = sat - lane_b;
    end

endmodule

`default_nettype wire

/* turbo_shuffle.sv */
`timescale 1ns/1ps
`default_nettype none

module turbo_shuffle import alu_pkg::*; (
    input  simd_word_u operand_a_i,
    input  simd_word_u operand_b_i,
    output xlen_t      shuffle_o
);

    logic [SHUF_LANES-1:0][SHUF_IDX_W-1:0] lane_idx;
    logic [SHUF_LANES-1:0]                 lane_mask;
    simd_word_u                            shuffled;

    // ------------------------------------------------------------------
    // index and mask per destination lane
    // ------------------------------------------------------------------
    for (genvar i = 0; i < SHUF_LANES; i++) begin : gen_ctrl
        // low nibble of the same b lane picks the source byte
        assign lane_idx[i] = operand_b_i.lanes[i][SHUF_IDX_W-1:0];

        // a b byte of exactly 1 zeroes the lane
        assign lane_mask[i] = (operand_b_i.lanes[i] == lane_t'(1));
    end

    // ------------------------------------------------------------------
    // byte select
    // ------------------------------------------------------------------
    always_comb begin
        // upper lanes are never filled
        shuffled.scalar = '0;
        for (int i = 0; i < SHUF_LANES; i++) begin
            if (lane_mask[i]) begin
                shuffled.lanes[i] = '0;
            end else if (lane_idx[i] < SHUF_LANES) begin
                shuffled.lanes[i] =
                    operand_a_i.lanes[lane_idx[i][$clog2(SHUF_LANES)-1:0]];
            end else begin
                // out of range index
                shuffled.lanes[i] = '0;
            end
        end
    end

    assign shuffle_o = shuffled.scalar;

endmodule

`default_nettype wire
